//--- Makefile
VERILATOR  ?= verilator
TOP        := uart_axil_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q -F '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/uart_axil_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module uart_axil_asserts import uart_pkg::*; (
	input	logic			clk,
	input	logic			rst,
	input	logic			bvalid_o,
	input	logic			bready_i,
	input	axil_resp_t		bresp_o,
	input	logic			rvalid_o,
	input	logic			rready_i,
	input	axil_resp_t		rresp_o,
	input	axil_data_t		rdata_o,
	input	logic			rts_o,
	input	logic			tx_o
);

	// responses hold until taken
	bresp_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
		else $error("write response changed before bready_i");

	rresp_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rresp_o) && $stable(rdata_o))
		else $error("read response changed before rready_i");

	reset_idle: assert property (@(posedge clk) rst |-> !rts_o && !bvalid_o && tx_o)
		else $error("outputs not idle during reset");

endmodule : uart_axil_asserts

bind uart_axil uart_axil_asserts asserts0 (.*);

`default_nettype wire

//--- bench/uart_axil_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_axil_tb import uart_pkg::*; ();

	localparam int HALF = 5;
	localparam int LIMIT = 2000;	// cycles per wait
	localparam int BIT = 8;			// test divisor
	localparam int TX_DEPTH = 1 << `UART_TX_DEPTH_LOG2;
	localparam int RX_DEPTH = 1 << `UART_RX_DEPTH_LOG2;

	logic			clk, rst;
	logic			awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
	axil_addr_t		awaddr_i, araddr_i;
	axil_data_t		wdata_i, rdata_o;
	logic [3:0]		wstrb_i;
	logic			awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
	axil_resp_t		bresp_o, rresp_o;
	logic			rx_i, tx_o, cts_i, rts_o;

	logic [31:0]	rng = 32'd58;
	uart_byte_t		line_q [$];		// bytes seen on tx_o
	string			cur_test;
	int				test_errors, total_errors, tests_run, failed_tests;

	uart_axil dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic abort_run(input string why);
		$display("Timeout in %s: no %s", cur_test, why);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic report_mismatch(input string what, input axil_data_t exp,
			input axil_data_t act);
		$display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
		test_errors++;
	endtask

	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
			output axil_resp_t resp);
		int n;
		n = 0;
		@(negedge clk);
		awvalid_i = 1'b1;
		wvalid_i = 1'b1;
		awaddr_i = addr;
		wdata_i = data;
		#1;
		while (!(awready_o && wready_o)) begin
			n = n + 1;
			if (n > LIMIT)
				abort_run("awready_o and wready_o");
			@(negedge clk);
			#1;
		end
		@(negedge clk);		// taken on the edge just passed
		awvalid_i = 1'b0;
		wvalid_i = 1'b0;
		n = 0;
		while (!bvalid_o) begin
			n = n + 1;
			if (n > LIMIT)
				abort_run("bvalid_o");
			@(negedge clk);
		end
		resp = bresp_o;
		bready_i = 1'b1;
		@(negedge clk);
		bready_i = 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
			output axil_resp_t resp);
		int n;
		n = 0;
		@(negedge clk);
		arvalid_i = 1'b1;
		araddr_i = addr;
		#1;
		while (!arready_o) begin
			n = n + 1;
			if (n > LIMIT)
				abort_run("arready_o");
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		arvalid_i = 1'b0;
		n = 0;
		while (!rvalid_o) begin
			n = n + 1;
			if (n > LIMIT)
				abort_run("rvalid_o");
			@(negedge clk);
		end
		data = rdata_o;
		resp = rresp_o;
		rready_i = 1'b1;
		@(negedge clk);
		rready_i = 1'b0;
	endtask

	task automatic wait_rx_count(input int want, output axil_data_t cnt);
		axil_resp_t r;
		int n;
		n = 0;
		axil_read(`UART_RX_COUNT_ADDR, cnt, r);
		while (cnt < want) begin
			n = n + 1;
			if (n > 100)
				abort_run("receive count");
			axil_read(`UART_RX_COUNT_ADDR, cnt, r);
		end
	endtask

	// 8N1 frame on rx_i with the lsb first
	task automatic send_serial(input uart_byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		@(negedge clk);
		for (int i = 0; i < 10; i++) begin
			rx_i = frame[i];
			repeat (BIT) @(negedge clk);
		end
	endtask

	task automatic capture_bytes(input int count);
		uart_byte_t b;
		logic start_s;
		int n;
		for (int f = 0; f < count; f++) begin
			n = 0;
			@(negedge clk);
			while (tx_o) begin
				n = n + 1;
				if (n > LIMIT)
					abort_run("start bit on tx_o");
				@(negedge clk);
			end
			repeat (BIT / 2) @(negedge clk);	// middle of the start bit
			start_s = tx_o;
			for (int i = 0; i < 8; i++) begin
				repeat (BIT) @(negedge clk);
				b[i] = tx_o;
			end
			repeat (BIT) @(negedge clk);
			if (start_s || !tx_o) begin
				$display("%s: frame %0d on tx_o has a bad start or stop bit", cur_test, f);
				test_errors++;
			end
			line_q.push_back(b);
		end
	endtask

	task automatic quiet_line(input int cycles, input string why);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (!tx_o) begin
				$display("%s: tx_o left idle %s", cur_test, why);
				test_errors++;
				break;
			end
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, test_errors);
			failed_tests++;
		end
	endtask

	task automatic test_reset();
		axil_data_t d;
		axil_resp_t r;
		begin_test("reset values");
		axil_read(`UART_DIV_ADDR, d, r);
		if (d != 32'(`UART_DIV_RESET))
			report_mismatch("DIV", 32'(`UART_DIV_RESET), d);
		axil_read(`UART_STATUS_ADDR, d, r);
		if (d[3:0] != 4'b1010)	// tx_empty and rx_empty
			report_mismatch("STATUS", 32'hA, 32'(d[3:0]));
		axil_read(`UART_RX_COUNT_ADDR, d, r);
		if (d != 32'd0)
			report_mismatch("RX_COUNT", 32'd0, d);
		if (tx_o !== 1'b1)
			report_mismatch("tx_o", 32'd1, 32'(tx_o));
		if (rts_o !== 1'b0)
			report_mismatch("rts_o", 32'd0, 32'(rts_o));
		end_test();
	endtask

	task automatic test_transmit();
		axil_data_t d;
		axil_resp_t r;
		logic [31:0] x;
		uart_byte_t sent [$];
		begin_test("divisor and transmit");
		axil_write(`UART_DIV_ADDR, BIT, r);
		axil_read(`UART_DIV_ADDR, d, r);
		if (d != BIT)
			report_mismatch("DIV", BIT, d);
		for (int i = 0; i < 5; i++) begin
			x = xorshift32();
			sent.push_back(x[7:0]);
		end
		line_q.delete();
		fork
			for (int i = 0; i < 5; i++) begin
				axil_write(`UART_DATA_ADDR, {24'b0, sent[i]}, r);
				if (r != RESP_OKAY)
					report_mismatch("DATA write resp", 32'(RESP_OKAY), 32'(r));
			end
			capture_bytes(5);
		join
		for (int i = 0; i < 5; i++)
			if (line_q[i] != sent[i])
				report_mismatch("tx_o byte", 32'(sent[i]), 32'(line_q[i]));
		axil_read(`UART_STATUS_ADDR, d, r);
		if (d[3:0] != 4'b1010)
			report_mismatch("STATUS", 32'hA, 32'(d[3:0]));
		end_test();
	endtask

	task automatic test_receive();
		axil_data_t d;
		axil_resp_t r;
		logic [31:0] x;
		uart_byte_t sent [$];
		begin_test("receive");
		for (int i = 0; i < 4; i++) begin
			x = xorshift32();
			sent.push_back(x[7:0]);
			send_serial(x[7:0]);
		end
		wait_rx_count(4, d);
		if (d != 32'd4)
			report_mismatch("RX_COUNT", 32'd4, d);
		for (int i = 0; i < 4; i++) begin
			axil_read(`UART_DATA_ADDR, d, r);
			if (d != {24'b0, sent[i]})
				report_mismatch("DATA", {24'b0, sent[i]}, d);
			if (r != RESP_OKAY)
				report_mismatch("DATA resp", 32'(RESP_OKAY), 32'(r));
		end
		axil_read(`UART_DATA_ADDR, d, r);
		if (d != 32'd0)
			report_mismatch("empty DATA", 32'd0, d);
		if (r != RESP_SLVERR)
			report_mismatch("empty DATA resp", 32'(RESP_SLVERR), 32'(r));
		end_test();
	endtask

	task automatic test_errors_resp();
		axil_data_t d;
		axil_resp_t r;
		axil_addr_t bad [3];
		begin_test("error responses");
		bad = '{`UART_RX_COUNT_ADDR, `UART_STATUS_ADDR, 4'h1};
		for (int i = 0; i < 3; i++) begin
			axil_write(bad[i], 32'h5A, r);
			if (r != RESP_SLVERR)
				report_mismatch("write resp", 32'(RESP_SLVERR), 32'(r));
		end
		axil_read(4'h3, d, r);
		if (d != 32'd0)
			report_mismatch("read 0x3 data", 32'd0, d);
		if (r != RESP_SLVERR)
			report_mismatch("read 0x3 resp", 32'(RESP_SLVERR), 32'(r));
		axil_read(`UART_DIV_ADDR, d, r);
		if (d != BIT)
			report_mismatch("DIV", BIT, d);
		end_test();
	endtask

	task automatic test_flow_control();
		axil_data_t d;
		axil_resp_t r;
		logic [31:0] x;
		logic want_rts;
		int fill;
		uart_byte_t sent [$];
		begin_test("flow control");
		for (int i = 0; i < RX_DEPTH + 2; i++) begin
			x = xorshift32();
			if (i < RX_DEPTH)
				sent.push_back(x[7:0]);
			send_serial(x[7:0]);
			fill = (i < RX_DEPTH) ? i + 1 : RX_DEPTH;	// extra bytes are dropped
			wait_rx_count(fill, d);
			if (d != fill)
				report_mismatch("RX_COUNT", fill, d);
			want_rts = (RX_DEPTH - fill) < `UART_RTS_MARGIN;
			if (rts_o !== want_rts)
				report_mismatch("rts_o", 32'(want_rts), 32'(rts_o));
		end
		axil_read(`UART_STATUS_ADDR, d, r);
		if (d[3:0] != 4'b1001)	// tx_empty and rx_full
			report_mismatch("STATUS", 32'h9, 32'(d[3:0]));
		for (int i = 0; i < RX_DEPTH; i++) begin
			axil_read(`UART_DATA_ADDR, d, r);
			if (d != {24'b0, sent[i]})
				report_mismatch("DATA", {24'b0, sent[i]}, d);
		end
		if (rts_o !== 1'b0)
			report_mismatch("rts_o after drain", 32'd0, 32'(rts_o));
		@(negedge clk);
		cts_i = 1'b1;
		x = xorshift32();
		axil_write(`UART_DATA_ADDR, {24'b0, x[7:0]}, r);
		quiet_line(20 * BIT, "while cts_i is high");
		@(negedge clk);
		cts_i = 1'b0;
		line_q.delete();
		capture_bytes(1);
		if (line_q[0] != x[7:0])
			report_mismatch("tx_o byte", 32'(x[7:0]), 32'(line_q[0]));
		end_test();
	endtask

	task automatic test_tx_overflow();
		axil_data_t d;
		axil_resp_t r;
		axil_resp_t want;
		logic [31:0] x;
		uart_byte_t sent [$];
		begin_test("transmit overflow");
		@(negedge clk);
		cts_i = 1'b1;
		for (int i = 0; i < TX_DEPTH + 2; i++) begin
			x = xorshift32();
			if (i < TX_DEPTH)
				sent.push_back(x[7:0]);
			axil_write(`UART_DATA_ADDR, {24'b0, x[7:0]}, r);
			want = (i < TX_DEPTH) ? RESP_OKAY : RESP_SLVERR;
			if (r != want)
				report_mismatch("DATA write resp", 32'(want), 32'(r));
		end
		axil_read(`UART_STATUS_ADDR, d, r);
		if (d[2] != 1'b1)
			report_mismatch("STATUS tx_full", 32'd1, 32'(d[2]));
		@(negedge clk);
		cts_i = 1'b0;
		line_q.delete();
		capture_bytes(TX_DEPTH);
		for (int i = 0; i < TX_DEPTH; i++)
			if (line_q[i] != sent[i])
				report_mismatch("tx_o byte", 32'(sent[i]), 32'(line_q[i]));
		quiet_line(20 * BIT, "after the last queued byte");
		end_test();
	endtask

	initial begin
		rst = 1'b1;
		awvalid_i = 1'b0;
		awaddr_i = '0;
		wvalid_i = 1'b0;
		wdata_i = '0;
		wstrb_i = 4'hF;
		bready_i = 1'b0;
		arvalid_i = 1'b0;
		araddr_i = '0;
		rready_i = 1'b0;
		rx_i = 1'b1;
		cts_i = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_reset();
		test_transmit();
		test_receive();
		test_errors_resp();
		test_flow_control();
		test_tx_overflow();
		$display("%0d tests, %0d failed, %0d errors", tests_run, failed_tests, total_errors);
		if (failed_tests == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule : uart_axil_tb

`default_nettype wire

//--- flist.f
+incdir+source
source/uart_pkg.sv
source/sync_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_axil_regs.sv
source/uart_axil.sv
bench/uart_axil_asserts.sv
bench/uart_axil_tb.sv

//--- source/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo import uart_pkg::*; #(
	parameter int DEPTH_LOG2 = 4
) (
	input	logic			clk,
	input	logic			rst,
	input	logic			push_i,
	input	uart_byte_t		data_i,
	input	logic			pop_i,
	output	uart_byte_t		head_o,
	output	fifo_count_t	count_o,
	output	logic			empty_o,
	output	logic			full_o
);

	localparam fifo_count_t DEPTH = fifo_count_t'(1 << DEPTH_LOG2);

	uart_byte_t				mem [0:(1 << DEPTH_LOG2) - 1];
	logic [DEPTH_LOG2-1:0]	wr_ptr;
	logic [DEPTH_LOG2-1:0]	rd_ptr;
	fifo_count_t			count;
	logic					do_push;
	logic					do_pop;

	assign do_push = push_i && !full_o;	// full fifo drops the byte
	assign do_pop = pop_i && !empty_o;
	assign empty_o = (count == '0);
	assign full_o = (count == DEPTH);
	assign head_o = mem[rd_ptr];		// fall through
	assign count_o = count;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule : sync_fifo

`default_nettype wire

//--- source/uart_axil.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_axil import uart_pkg::*; (
	input	logic			clk,
	input	logic			rst,
	input	logic			awvalid_i,
	input	axil_addr_t		awaddr_i,
	input	logic			wvalid_i,
	input	axil_data_t		wdata_i,
	input	logic [3:0]		wstrb_i,
	input	logic			bready_i,
	input	logic			arvalid_i,
	input	axil_addr_t		araddr_i,
	input	logic			rready_i,
	output	logic			awready_o,
	output	logic			wready_o,
	output	logic			bvalid_o,
	output	axil_resp_t		bresp_o,
	output	logic			arready_o,
	output	logic			rvalid_o,
	output	axil_data_t		rdata_o,
	output	axil_resp_t		rresp_o,
	input	logic			rx_i,
	output	logic			tx_o,
	input	logic			cts_i,	// high holds off the next frame
	output	logic			rts_o	// high when rx space runs low
);

	uart_div_t		div;
	logic			tx_push, tx_pop, rx_push, rx_pop;
	uart_byte_t		tx_data, tx_head, rx_data, rx_head;
	fifo_count_t	tx_count, rx_count;
	logic			tx_empty, tx_full, rx_empty, rx_full;
	uart_status_t	status;

	assign status = {tx_empty, tx_full, rx_empty, rx_full};

	uart_axil_regs regs0 (.*, .tx_count_i(tx_count), .rx_count_i(rx_count),
		.tx_status_i(status), .rx_head_i(rx_head), .tx_push_o(tx_push),
		.tx_data_o(tx_data), .rx_pop_o(rx_pop), .div_o(div));

	sync_fifo #(.DEPTH_LOG2(`UART_TX_DEPTH_LOG2)) tx_fifo (.clk, .rst,
		.push_i(tx_push), .data_i(tx_data), .pop_i(tx_pop), .head_o(tx_head),
		.count_o(tx_count), .empty_o(tx_empty), .full_o(tx_full));

	sync_fifo #(.DEPTH_LOG2(`UART_RX_DEPTH_LOG2)) rx_fifo (.clk, .rst,
		.push_i(rx_push), .data_i(rx_data), .pop_i(rx_pop), .head_o(rx_head),
		.count_o(rx_count), .empty_o(rx_empty), .full_o(rx_full));

	uart_tx tx0 (.clk, .rst, .div_i(div), .data_i(tx_head), .empty_i(tx_empty),
		.cts_i, .pop_o(tx_pop), .tx_o);

	uart_rx rx0 (.clk, .rst, .div_i(div), .rx_i, .valid_o(rx_push), .data_o(rx_data));

endmodule : uart_axil

`default_nettype wire

//--- source/uart_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_axil_regs import uart_pkg::*; (
	input	logic			clk,
	input	logic			rst,
	input	logic			awvalid_i,
	input	axil_addr_t		awaddr_i,
	input	logic			wvalid_i,
	input	axil_data_t		wdata_i,
	input	logic [3:0]		wstrb_i,	// registers are written whole
	input	logic			bready_i,
	input	logic			arvalid_i,
	input	axil_addr_t		araddr_i,
	input	logic			rready_i,
	output	logic			awready_o,
	output	logic			wready_o,
	output	logic			bvalid_o,
	output	axil_resp_t		bresp_o,
	output	logic			arready_o,
	output	logic			rvalid_o,
	output	axil_data_t		rdata_o,
	output	axil_resp_t		rresp_o,
	input	fifo_count_t	tx_count_i,
	input	fifo_count_t	rx_count_i,
	input	uart_status_t	tx_status_i,	// flags of both fifos
	input	uart_byte_t		rx_head_i,
	output	logic			tx_push_o,
	output	uart_byte_t		tx_data_o,
	output	logic			rx_pop_o,
	output	uart_div_t		div_o,
	output	logic			rts_o
);

	localparam fifo_count_t RX_DEPTH = fifo_count_t'(1 << `UART_RX_DEPTH_LOG2);

	logic			live_q;		// up one cycle after reset
	logic			wr_accept;
	logic			rd_accept;
	axil_resp_t		wr_resp;
	axil_resp_t		rd_resp;
	axil_data_t		rd_data;
	uart_div_t		div_q;
	fifo_count_t	rx_free;
	logic			bvalid_q;
	logic			rvalid_q;
	logic			rts_q;
	axil_resp_t		bresp_q;
	axil_resp_t		rresp_q;
	axil_data_t		rdata_q;

	// address and data taken together
	assign wr_accept = live_q && awvalid_i && wvalid_i && !bvalid_q;
	assign awready_o = wr_accept;
	assign wready_o = wr_accept;
	assign arready_o = live_q && !rvalid_q;
	assign rd_accept = arvalid_i && arready_o;

	assign tx_data_o = wdata_i[7:0];
	assign rx_free = RX_DEPTH - rx_count_i;

	always_comb begin
		wr_resp = RESP_OKAY;
		tx_push_o = 1'b0;
		case (awaddr_i)
			`UART_DATA_ADDR: begin
				if (tx_status_i.tx_full)
					wr_resp = RESP_SLVERR;	// byte dropped
				else
					tx_push_o = wr_accept;
			end
			`UART_DIV_ADDR: wr_resp = RESP_OKAY;
			default: wr_resp = RESP_SLVERR;
		endcase
	end

	always_comb begin
		rd_resp = RESP_OKAY;
		rd_data = '0;
		rx_pop_o = 1'b0;
		case (araddr_i)
			`UART_DATA_ADDR: begin
				if (tx_status_i.rx_empty) begin
					rd_resp = RESP_SLVERR;
				end else begin
					rd_data = {24'b0, rx_head_i};
					rx_pop_o = rd_accept;
				end
			end
			`UART_RX_COUNT_ADDR: rd_data = {27'b0, rx_count_i};
			// tx occupancy rides along in 12:8
			`UART_STATUS_ADDR: rd_data = {19'b0, tx_count_i, 4'b0, tx_status_i};
			`UART_DIV_ADDR: rd_data = {16'b0, div_q};
			default: rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			live_q <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			div_q <= `UART_DIV_RESET;
			rts_q <= 1'b0;
		end else begin
			live_q <= 1'b1;
			if (wr_accept)
				bvalid_q <= 1'b1;
			else if (bready_i)
				bvalid_q <= 1'b0;
			if (rd_accept)
				rvalid_q <= 1'b1;
			else if (rready_i)
				rvalid_q <= 1'b0;
			if (wr_accept && awaddr_i == `UART_DIV_ADDR)
				div_q <= wdata_i[15:0];
			rts_q <= (rx_free < fifo_count_t'(`UART_RTS_MARGIN));
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept)
			bresp_q <= wr_resp;
		if (rd_accept) begin
			rresp_q <= rd_resp;
			rdata_q <= rd_data;
		end
	end

	assign bvalid_o = bvalid_q;
	assign bresp_o = bresp_q;
	assign rvalid_o = rvalid_q;
	assign rresp_o = rresp_q;
	assign rdata_o = rdata_q;
	assign div_o = div_q;
	assign rts_o = rts_q;

endmodule : uart_axil_regs

`default_nettype wire

//--- source/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// clocks per bit after reset, 115200 baud from a 50 MHz clock
`define UART_DIV_RESET		16'd434

// fifo depths as powers of two
`define UART_TX_DEPTH_LOG2	4
`define UART_RX_DEPTH_LOG2	3

// rts goes up when fewer free rx entries than this remain
`define UART_RTS_MARGIN		2

// register map, byte addresses
`define UART_DATA_ADDR		4'h0
`define UART_RX_COUNT_ADDR	4'h4
`define UART_STATUS_ADDR	4'h8
`define UART_DIV_ADDR		4'hC

`endif

//--- source/uart_pkg.sv
`default_nettype none

package uart_pkg;

	typedef logic [7:0]		uart_byte_t;
	typedef logic [31:0]	axil_data_t;
	typedef logic [3:0]		axil_addr_t;
	typedef logic [15:0]	uart_div_t;		// clocks per bit
	typedef logic [4:0]		fifo_count_t;	// holds 0..16
	typedef logic [1:0]		axil_resp_t;

	localparam axil_resp_t RESP_OKAY	= 2'b00;
	localparam axil_resp_t RESP_SLVERR	= 2'b10;

	// read back in STATUS[3:0], tx_empty on top
	typedef struct packed {
		logic tx_empty;
		logic tx_full;
		logic rx_empty;
		logic rx_full;
	} uart_status_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage : uart_pkg

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
	input	logic			clk,
	input	logic			rst,
	input	uart_div_t		div_i,
	input	logic			rx_i,
	output	logic			valid_o,
	output	uart_byte_t		data_o
);

	logic			rx_meta;
	logic			rx_sync;
	logic			rx_prev;
	rx_state_t		state;
	uart_div_t		bit_cnt;
	uart_div_t		half;
	logic [2:0]		bit_idx;
	uart_byte_t		shift;
	logic			valid_q;
	logic			bit_end;
	logic			half_end;

	assign half = div_i >> 1;
	assign bit_end = (bit_cnt == div_i - 1'b1);
	assign half_end = (bit_cnt == half - 1'b1);
	assign valid_o = valid_q;
	assign data_o = shift;

	// two flop synchronizer, plus one for the edge
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end)
			shift <= {rx_sync, shift[7:1]};
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= RX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			bit_cnt <= bit_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					bit_cnt <= '0;
					if (rx_prev && !rx_sync)	// falling edge
						state <= RX_START;
				end
				RX_START: if (half_end) begin
					bit_cnt <= '0;
					bit_idx <= '0;
					// glitch shorter than half a bit goes back to idle
					state <= rx_sync ? RX_IDLE : RX_DATA;
				end
				RX_DATA: if (bit_end) begin
					bit_cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end
				RX_STOP: if (bit_end) begin
					valid_q <= rx_sync;	// low stop bit is a framing error
					state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule : uart_rx

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
	input	logic			clk,
	input	logic			rst,
	input	uart_div_t		div_i,
	input	uart_byte_t		data_i,
	input	logic			empty_i,
	input	logic			cts_i,
	output	logic			pop_o,
	output	logic			tx_o
);

	tx_state_t		state;
	uart_div_t		bit_cnt;
	logic [2:0]		bit_idx;
	uart_byte_t		shift;
	logic			tx_q;
	logic			bit_end;
	logic			load;

	assign bit_end = (bit_cnt == div_i - 1'b1);

	// cts only matters between frames
	assign load = ((state == TX_IDLE) || (state == TX_STOP && bit_end)) && !empty_i && !cts_i;
	assign pop_o = load;
	assign tx_o = tx_q;

	always_ff @(posedge clk) begin
		if (load)
			shift <= data_i;
		else if (bit_end && (state == TX_START || state == TX_DATA))
			shift <= shift >> 1;	// lsb first
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= TX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			tx_q <= 1'b1;
		end else if (load) begin
			state <= TX_START;
			bit_cnt <= '0;
			tx_q <= 1'b0;	// start bit
		end else begin
			bit_cnt <= (bit_end || state == TX_IDLE) ? '0 : bit_cnt + 1'b1;
			case (state)
				TX_START: if (bit_end) begin
					tx_q <= shift[0];
					bit_idx <= '0;
					state <= TX_DATA;
				end
				TX_DATA: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						tx_q <= 1'b1;	// stop bit
						state <= TX_STOP;
					end else begin
						tx_q <= shift[0];
						bit_idx <= bit_idx + 1'b1;
					end
				end
				TX_STOP: if (bit_end)
					state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule : uart_tx

`default_nettype wire
